// File: hw/cgra_pkg.sv
`default_nettype none

package cgra_pkg;

   // datapath sizes
   localparam int data_w     = 32;
   localparam int n_mem      = 2;
   localparam int mem_addr_w = 6;
   localparam int n_alu      = 2;
   localparam int n_mul      = 1;

   // data bus slots
   localparam int n_slots    = 8;
   localparam int sel_w      = 3;
   localparam int slot_mem0a = 0;
   localparam int slot_mem0b = 1;
   localparam int slot_mem1a = 2;
   localparam int slot_mem1b = 3;
   localparam int slot_alu0  = 4;
   localparam int slot_alu1  = 5;
   localparam int slot_mul0  = 6;
   localparam int slot_zero  = 7;
   localparam int databus_w  = n_slots * data_w;

   // configuration words, mem0 A/B then mem1 A/B, alus, multiplier
   localparam int n_conf        = 7;
   localparam int conf_mem_base = 0;
   localparam int conf_alu_base = 4;
   localparam int conf_mul_base = 6;
   localparam int conf_addr_w   = 3;
   localparam int conf_bits     = n_conf * data_w;

   // host address: bit 7 control, bit 6 memory, bits 5..0 word
   localparam int host_addr_w = 8;

   localparam logic [2:0] fn_add    = 3'd0;
   localparam logic [2:0] fn_sub    = 3'd1;
   localparam logic [2:0] fn_and    = 3'd2;
   localparam logic [2:0] fn_or     = 3'd3;
   localparam logic [2:0] fn_xor    = 3'd4;
   localparam logic [2:0] fn_max    = 3'd5;
   localparam logic [2:0] fn_min    = 3'd6;
   localparam logic [2:0] fn_pass_a = 3'd7;

   // one config word, read as a memory port or as an alu/mul setup
   typedef union packed {
      struct packed {
         logic [4:0]            unused;
         logic                  en;
         logic                  wr;
         logic [sel_w-1:0]      sel;
         logic [mem_addr_w-1:0] start;
         logic [mem_addr_w-1:0] incr;
         logic [mem_addr_w-1:0] iter;
         logic [3:0]            delay;
      } mem_port;
      struct packed {
         logic [22:0]      unused;
         logic [2:0]       fn;
         logic [sel_w-1:0] sel_a;
         logic [sel_w-1:0] sel_b;
      } alu;
   } conf_word_u;

endpackage

`default_nettype wire

// File: hw/cgra_conf_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_conf_regs (
   input  wire                                rst,
   input  wire                                clk,
   input  wire                                conf_valid,
   input  wire  [cgra_pkg::conf_addr_w-1:0]   conf_addr,
   input  wire  [cgra_pkg::data_w-1:0]        conf_wdata,
   output logic [cgra_pkg::conf_bits-1:0]     config_bus
);

   logic [cgra_pkg::data_w-1:0] conf_mem [cgra_pkg::n_conf];

   // host writes one word per strobe
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         for (int i = 0; i < cgra_pkg::n_conf; i++) begin
            conf_mem[i] <= '0;
         end
      end else if (conf_valid && (int'(conf_addr) < cgra_pkg::n_conf)) begin
         conf_mem[conf_addr] <= conf_wdata;
      end
   end

   // word 0 sits in the lowest bits
   always_comb begin
      for (int i = 0; i < cgra_pkg::n_conf; i++) begin
         config_bus[i*cgra_pkg::data_w +: cgra_pkg::data_w] = conf_mem[i];
      end
   end

endmodule

`default_nettype wire

// File: hw/cgra_mem.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_mem (
   input  wire                               rst,
   input  wire                               clk,
   input  wire                               run_pulse,
   input  wire                               host_valid,
   input  wire                               host_we,
   input  wire  [cgra_pkg::mem_addr_w-1:0]   host_addr,
   input  wire  [cgra_pkg::data_w-1:0]       host_wdata,
   input  wire  [cgra_pkg::databus_w-1:0]    data_bus,
   input  wire  cgra_pkg::conf_word_u        conf_a,
   input  wire  cgra_pkg::conf_word_u        conf_b,
   output logic [cgra_pkg::data_w-1:0]       out_a,
   output logic [cgra_pkg::data_w-1:0]       out_b,
   output logic                              done_a,
   output logic                              done_b
);

   logic [cgra_pkg::data_w-1:0] mem [2**cgra_pkg::mem_addr_w];

   cgra_pkg::conf_word_u conf [2];

   // generator state per port
   logic [3:0]                    dly [2];
   logic [cgra_pkg::mem_addr_w-1:0] ptr [2];
   logic [cgra_pkg::mem_addr_w-1:0] rem [2];
   logic [1:0]                    busy;
   logic [1:0]                    starting;

   // array access per port
   logic [cgra_pkg::mem_addr_w-1:0] acc_addr [2];
   logic [cgra_pkg::data_w-1:0]     wr_word [2];
   logic [1:0]                    wr_en;
   logic [1:0]                    rd_en;

   assign conf[0] = conf_a;
   assign conf[1] = conf_b;

   always_comb begin
      for (int p = 0; p < 2; p++) begin
         starting[p] = run_pulse & conf[p].mem_port.en & (conf[p].mem_port.iter != '0);
         acc_addr[p] = ptr[p];
         wr_word[p]  = data_bus[conf[p].mem_port.sel*cgra_pkg::data_w +: cgra_pkg::data_w];
         wr_en[p]    = busy[p] & (dly[p] == '0) & conf[p].mem_port.wr;
         rd_en[p]    = busy[p] & (dly[p] == '0) & ~conf[p].mem_port.wr;
      end
      // host owns port A while its generator is idle
      if (!busy[0]) begin
         acc_addr[0] = host_addr;
         wr_word[0]  = host_wdata;
         wr_en[0]    = host_valid & host_we;
         rd_en[0]    = host_valid & ~host_we;
      end
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         busy <= '0;
         for (int p = 0; p < 2; p++) begin
            dly[p] <= '0;
            ptr[p] <= '0;
            rem[p] <= '0;
         end
      end else begin
         for (int p = 0; p < 2; p++) begin
            if (run_pulse) begin
               busy[p] <= starting[p];
               dly[p]  <= conf[p].mem_port.delay;
               ptr[p]  <= conf[p].mem_port.start;
               rem[p]  <= conf[p].mem_port.iter;
            end else if (busy[p]) begin
               if (dly[p] != '0) begin
                  dly[p] <= dly[p] - 1'b1;
               end else begin
                  // one access this cycle, step wraps at 64
                  ptr[p] <= ptr[p] + conf[p].mem_port.incr;
                  rem[p] <= rem[p] - 1'b1;
                  if (rem[p] == 1) begin
                     busy[p] <= 1'b0;
                  end
               end
            end
         end
      end
   end

   // shared array, port B wins a same-address collision
   always_ff @(posedge rst) begin
      for (int p = 0; p < 2; p++) begin
         if (wr_en[p]) begin
            mem[acc_addr[p]] <= wr_word[p];
         end
      end
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         out_a <= '0;
         out_b <= '0;
      end else begin
         if (rd_en[0]) begin
            out_a <= mem[acc_addr[0]];
         end
         if (rd_en[1]) begin
            out_b <= mem[acc_addr[1]];
         end
      end
   end

   assign done_a = ~busy[0] & ~starting[0];
   assign done_b = ~busy[1] & ~starting[1];

endmodule

`default_nettype wire

// File: hw/cgra_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_alu (
   input  wire                               rst,
   input  wire                               clk,
   input  wire                               run_pulse,
   input  wire  [cgra_pkg::databus_w-1:0]    data_bus,
   input  wire  cgra_pkg::conf_word_u        conf,
   output logic [cgra_pkg::data_w-1:0]       result
);

   logic signed [cgra_pkg::data_w-1:0] op_a;
   logic signed [cgra_pkg::data_w-1:0] op_b;
   logic        [cgra_pkg::data_w-1:0] res_next;

   // operand pick from the bus
   assign op_a = data_bus[conf.alu.sel_a*cgra_pkg::data_w +: cgra_pkg::data_w];
   assign op_b = data_bus[conf.alu.sel_b*cgra_pkg::data_w +: cgra_pkg::data_w];

   always_comb begin
      case (conf.alu.fn)
         cgra_pkg::fn_add: res_next = op_a + op_b;
         cgra_pkg::fn_sub: res_next = op_a - op_b;
         cgra_pkg::fn_and: res_next = op_a & op_b;
         cgra_pkg::fn_or:  res_next = op_a | op_b;
         cgra_pkg::fn_xor: res_next = op_a ^ op_b;
         // signed compare
         cgra_pkg::fn_max: res_next = (op_a > op_b) ? op_a : op_b;
         cgra_pkg::fn_min: res_next = (op_a < op_b) ? op_a : op_b;
         default:          res_next = op_a;
      endcase
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else if (run_pulse) begin
         result <= '0;
      end else begin
         result <= res_next;
      end
   end

endmodule

`default_nettype wire

// File: hw/cgra_mul.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_mul (
   input  wire                               rst,
   input  wire                               clk,
   input  wire                               run_pulse,
   input  wire  [cgra_pkg::databus_w-1:0]    data_bus,
   input  wire  cgra_pkg::conf_word_u        conf,
   output logic [cgra_pkg::data_w-1:0]       result
);

   // stage 1 operand registers
   logic [cgra_pkg::data_w-1:0] op_a_q;
   logic [cgra_pkg::data_w-1:0] op_b_q;

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         op_a_q <= '0;
         op_b_q <= '0;
         result <= '0;
      end else if (run_pulse) begin
         op_a_q <= '0;
         op_b_q <= '0;
         result <= '0;
      end else begin
         op_a_q <= data_bus[conf.alu.sel_a*cgra_pkg::data_w +: cgra_pkg::data_w];
         op_b_q <= data_bus[conf.alu.sel_b*cgra_pkg::data_w +: cgra_pkg::data_w];
         // stage 2, low half of the product
         result <= op_a_q * op_b_q;
      end
   end

endmodule

`default_nettype wire

// File: hw/cgra_data_eng.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_data_eng (
   input  wire                                rst,
   input  wire                                clk,
   input  wire                                valid,
   input  wire                                we,
   input  wire  [cgra_pkg::host_addr_w-1:0]   addr,
   input  wire  [cgra_pkg::data_w-1:0]        data_in,
   input  wire  [cgra_pkg::conf_bits-1:0]     config_bus,
   output logic [cgra_pkg::data_w-1:0]        data_out,
   output logic                               done
);

   logic [cgra_pkg::databus_w-1:0] data_bus;
   logic [cgra_pkg::conf_bits-1:0] shadow;
   logic [cgra_pkg::n_mem-1:0]     mem_sel;
   logic [2*cgra_pkg::n_mem-1:0]   port_done;
   logic                           ctrl_sel;
   logic                           run_req;
   logic                           run_pulse;
   logic                           mem_idx_q;

   // address decode
   assign ctrl_sel = valid & addr[cgra_pkg::host_addr_w-1];
   assign run_req  = ctrl_sel & we & data_in[0];

   always_comb begin
      mem_sel = '0;
      if (valid && !addr[cgra_pkg::host_addr_w-1]) begin
         mem_sel[addr[cgra_pkg::mem_addr_w]] = 1'b1;
      end
   end

   // run pulse, config shadow and read-back index
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         run_pulse <= 1'b0;
         shadow    <= '0;
         mem_idx_q <= 1'b0;
      end else begin
         run_pulse <= run_req;
         if (run_req) begin
            shadow <= config_bus;
         end
         if (valid && !addr[cgra_pkg::host_addr_w-1]) begin
            mem_idx_q <= addr[cgra_pkg::mem_addr_w];
         end
      end
   end

   assign data_bus[cgra_pkg::slot_zero*cgra_pkg::data_w +: cgra_pkg::data_w] = '0;

   for (genvar i = 0; i < cgra_pkg::n_mem; i++) begin : g_mem
      cgra_mem u_mem (
         .rst        (rst),
         .clk        (clk),
         .run_pulse  (run_pulse),
         .host_valid (mem_sel[i]),
         .host_we    (we),
         .host_addr  (addr[cgra_pkg::mem_addr_w-1:0]),
         .host_wdata (data_in),
         .data_bus   (data_bus),
         .conf_a     (shadow[(cgra_pkg::conf_mem_base+2*i)*cgra_pkg::data_w +: cgra_pkg::data_w]),
         .conf_b     (shadow[(cgra_pkg::conf_mem_base+2*i+1)*cgra_pkg::data_w +: cgra_pkg::data_w]),
         .out_a      (data_bus[(cgra_pkg::slot_mem0a+2*i)*cgra_pkg::data_w +: cgra_pkg::data_w]),
         .out_b      (data_bus[(cgra_pkg::slot_mem0b+2*i)*cgra_pkg::data_w +: cgra_pkg::data_w]),
         .done_a     (port_done[2*i]),
         .done_b     (port_done[2*i+1])
      );
   end

   for (genvar i = 0; i < cgra_pkg::n_alu; i++) begin : g_alu
      cgra_alu u_alu (
         .rst       (rst),
         .clk       (clk),
         .run_pulse (run_pulse),
         .data_bus  (data_bus),
         .conf      (shadow[(cgra_pkg::conf_alu_base+i)*cgra_pkg::data_w +: cgra_pkg::data_w]),
         .result    (data_bus[(cgra_pkg::slot_alu0+i)*cgra_pkg::data_w +: cgra_pkg::data_w])
      );
   end

   for (genvar i = 0; i < cgra_pkg::n_mul; i++) begin : g_mul
      cgra_mul u_mul (
         .rst       (rst),
         .clk       (clk),
         .run_pulse (run_pulse),
         .data_bus  (data_bus),
         .conf      (shadow[(cgra_pkg::conf_mul_base+i)*cgra_pkg::data_w +: cgra_pkg::data_w]),
         .result    (data_bus[(cgra_pkg::slot_mul0+i)*cgra_pkg::data_w +: cgra_pkg::data_w])
      );
   end

   assign done = &port_done;

   // status now, memory word from the port A slot
   always_comb begin
      if (ctrl_sel) begin
         data_out = {{(cgra_pkg::data_w-1){1'b0}}, done};
      end else if (mem_idx_q) begin
         data_out = data_bus[cgra_pkg::slot_mem1a*cgra_pkg::data_w +: cgra_pkg::data_w];
      end else begin
         data_out = data_bus[cgra_pkg::slot_mem0a*cgra_pkg::data_w +: cgra_pkg::data_w];
      end
   end

endmodule

`default_nettype wire

// File: hw/cgra_top.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_top (
   input  wire                                rst,
   input  wire                                clk,
   input  wire                                conf_valid,
   input  wire  [cgra_pkg::conf_addr_w-1:0]   conf_addr,
   input  wire  [cgra_pkg::data_w-1:0]        conf_wdata,
   input  wire                                valid,
   input  wire                                we,
   input  wire  [cgra_pkg::host_addr_w-1:0]   addr,
   input  wire  [cgra_pkg::data_w-1:0]        data_in,
   output logic [cgra_pkg::data_w-1:0]        data_out,
   output logic                               done
);

   logic [cgra_pkg::conf_bits-1:0] config_bus;

   cgra_conf_regs u_conf (
      .rst        (rst),
      .clk        (clk),
      .conf_valid (conf_valid),
      .conf_addr  (conf_addr),
      .conf_wdata (conf_wdata),
      .config_bus (config_bus)
   );

   cgra_data_eng u_eng (
      .rst        (rst),
      .clk        (clk),
      .valid      (valid),
      .we         (we),
      .addr       (addr),
      .data_in    (data_in),
      .config_bus (config_bus),
      .data_out   (data_out),
      .done       (done)
   );

endmodule

`default_nettype wire

// File: dv/tb_cgra_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cgra_top;

   typedef struct packed {
      logic [1:0] unit;
      logic [2:0] fn;
      logic [5:0] n;
      logic [3:0] dly;
   } row_t;

   localparam int n_rows    = 18;
   localparam int max_polls = 100;

   // units 0 and 1 are the alus and 2 is the multiplier
   row_t rows [n_rows] = '{
      '{2'd0, cgra_pkg::fn_add,    6'd4, 4'd0},
      '{2'd1, cgra_pkg::fn_sub,    6'd5, 4'd1},
      '{2'd0, cgra_pkg::fn_and,    6'd3, 4'd2},
      '{2'd1, cgra_pkg::fn_or,     6'd4, 4'd0},
      '{2'd0, cgra_pkg::fn_xor,    6'd6, 4'd3},
      '{2'd1, cgra_pkg::fn_max,    6'd8, 4'd1},
      '{2'd0, cgra_pkg::fn_min,    6'd8, 4'd0},
      '{2'd1, cgra_pkg::fn_pass_a, 6'd3, 4'd5},
      '{2'd0, cgra_pkg::fn_sub,    6'd4, 4'd2},
      '{2'd1, cgra_pkg::fn_add,    6'd5, 4'd0},
      '{2'd0, cgra_pkg::fn_or,     6'd3, 4'd1},
      '{2'd1, cgra_pkg::fn_and,    6'd6, 4'd3},
      '{2'd0, cgra_pkg::fn_max,    6'd5, 4'd0},
      '{2'd1, cgra_pkg::fn_xor,    6'd4, 4'd2},
      '{2'd0, cgra_pkg::fn_pass_a, 6'd7, 4'd1},
      '{2'd1, cgra_pkg::fn_min,    6'd8, 4'd4},
      '{2'd2, cgra_pkg::fn_add,    6'd6, 4'd0},
      '{2'd2, cgra_pkg::fn_add,    6'd4, 4'd2}
   };

   // rst toggles as the clock and clk holds the reset
   logic                             rst;
   logic                             clk;
   logic                             conf_valid;
   logic [cgra_pkg::conf_addr_w-1:0] conf_addr;
   logic [31:0]                      conf_wdata;
   logic                             valid;
   logic                             we;
   logic [7:0]                       addr;
   logic [31:0]                      data_in;
   logic [31:0]                      data_out;
   logic                             done;
   integer                           seed;
   logic [31:0]                      op_a [64];
   logic [31:0]                      op_b [64];

   cgra_top u_dut (
      .rst(rst), .clk(clk), .conf_valid(conf_valid), .conf_addr(conf_addr),
      .conf_wdata(conf_wdata), .valid(valid), .we(we), .addr(addr),
      .data_in(data_in), .data_out(data_out), .done(done)
   );

   initial begin
      rst = 1'b0;
      forever #5 rst = ~rst;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else
         fail_run($sformatf("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp));
   endtask

   function automatic logic [7:0] mem_addr(input int m, input int a);
      return {1'b0, 1'(m), 6'(a)};
   endfunction

   // mem1 background that differs per row and address
   function automatic logic [31:0] fill_word(input int r, input int a);
      return {8'h5a, 8'(r), 10'd0, 6'(a)};
   endfunction

   function automatic logic [31:0] port_word(input logic wr, input int sel, input int start,
                                             input int iter, input int dly);
      cgra_pkg::conf_word_u w;
      w = '0;
      w.mem_port.en    = 1'b1;
      w.mem_port.wr    = wr;
      w.mem_port.sel   = 3'(sel);
      w.mem_port.start = 6'(start);
      w.mem_port.incr  = 6'd1;
      w.mem_port.iter  = 6'(iter);
      w.mem_port.delay = 4'(dly);
      return w;
   endfunction

   function automatic logic [31:0] unit_word(input logic [2:0] fn, input int sa, input int sb);
      cgra_pkg::conf_word_u w;
      w = '0;
      w.alu.fn    = fn;
      w.alu.sel_a = 3'(sa);
      w.alu.sel_b = 3'(sb);
      return w;
   endfunction

   // reference model of one alu or multiplier result
   function automatic logic [31:0] ref_result(input logic [1:0] unit, input logic [2:0] fn,
                                              input logic [31:0] a, input logic [31:0] b);
      logic signed [31:0] sa;
      logic signed [31:0] sb;
      sa = a;
      sb = b;
      if (unit == 2'd2) return a * b;
      case (fn)
         cgra_pkg::fn_add: return a + b;
         cgra_pkg::fn_sub: return a - b;
         cgra_pkg::fn_and: return a & b;
         cgra_pkg::fn_or:  return a | b;
         cgra_pkg::fn_xor: return a ^ b;
         cgra_pkg::fn_max: return (sa > sb) ? a : b;
         cgra_pkg::fn_min: return (sa < sb) ? a : b;
         default:          return a;
      endcase
   endfunction

   task automatic conf_write(input int a, input logic [31:0] w);
      @(negedge rst);
      conf_valid = 1'b1;
      conf_addr  = 3'(a);
      conf_wdata = w;
      @(negedge rst);
      conf_valid = 1'b0;
   endtask

   task automatic host_write(input logic [7:0] a, input logic [31:0] w);
      @(negedge rst);
      valid   = 1'b1;
      we      = 1'b1;
      addr    = a;
      data_in = w;
      @(negedge rst);
      valid = 1'b0;
      we    = 1'b0;
   endtask

   // memory word shows up one cycle after the strobe
   task automatic read_mem(input logic [7:0] a, output logic [31:0] d);
      @(negedge rst);
      valid = 1'b1;
      we    = 1'b0;
      addr  = a;
      @(negedge rst);
      valid = 1'b0;
      #1 d = data_out;
   endtask

   task automatic read_ctrl(output logic [31:0] d, output logic done_pin);
      @(negedge rst);
      valid = 1'b1;
      we    = 1'b0;
      addr  = 8'h80;
      #1 d = data_out;
      done_pin = done;
      @(negedge rst);
      valid = 1'b0;
   endtask

   task automatic write_check(input logic [7:0] a, input logic [31:0] w);
      logic [31:0] got;
      host_write(a, w);
      read_mem(a, got);
      check_word($sformatf("host read-back at %h", a), got, w);
   endtask

   initial begin
      logic [31:0] got;
      logic [31:0] exp;
      logic        done_pin;
      int          n;
      int          lat;
      int          unit_slot;
      int          unit_conf;
      int          polls;
      seed       = 66;
      clk        = 1'b1;
      conf_valid = 1'b0;
      conf_addr  = '0;
      conf_wdata = '0;
      valid      = 1'b0;
      we         = 1'b0;
      addr       = '0;
      data_in    = '0;
      repeat (10) @(negedge rst);
      clk = 1'b0;

      read_ctrl(got, done_pin);
      check_word("done after reset", got, 32'd1);
      check_word("done pin after reset", {31'd0, done_pin}, 32'd1);

      for (int r = 0; r < n_rows; r++) begin
         n         = int'(rows[r].n);
         lat       = (rows[r].unit == 2'd2) ? 3 : 2;
         unit_slot = (rows[r].unit == 2'd2) ? cgra_pkg::slot_mul0
                                            : cgra_pkg::slot_alu0 + int'(rows[r].unit);
         unit_conf = (rows[r].unit == 2'd2) ? cgra_pkg::conf_mul_base
                                            : cgra_pkg::conf_alu_base + int'(rows[r].unit);
         for (int k = 0; k < n; k++) begin
            op_a[k] = $random(seed);
            op_b[k] = $random(seed);
            write_check(mem_addr(0, k), op_a[k]);
            write_check(mem_addr(0, 32 + k), op_b[k]);
         end
         for (int k = 0; k < n + 2; k++) begin
            write_check(mem_addr(1, k), fill_word(r, k));
         end

         conf_write(cgra_pkg::conf_mem_base, port_word(1'b0, 0, 0, n, rows[r].dly));
         conf_write(cgra_pkg::conf_mem_base + 1, port_word(1'b0, 0, 32, n, rows[r].dly));
         conf_write(cgra_pkg::conf_mem_base + 2,
                    port_word(1'b1, unit_slot, 0, n, int'(rows[r].dly) + lat));
         conf_write(unit_conf, unit_word(rows[r].fn, cgra_pkg::slot_mem0a, cgra_pkg::slot_mem0b));

         host_write(8'h80, 32'd1);
         read_ctrl(got, done_pin);
         check_word($sformatf("row %0d done after start", r), got, 32'd0);
         check_word($sformatf("row %0d done pin after start", r), {31'd0, done_pin}, 32'd0);

         // these must not reach the running shadow
         conf_write(unit_conf, unit_word(~rows[r].fn, cgra_pkg::slot_zero, cgra_pkg::slot_zero));
         conf_write(cgra_pkg::conf_mem_base + 2, 32'd0);

         polls = 0;
         got   = '0;
         while (got !== 32'd1) begin
            if (polls == max_polls) begin
               fail_run($sformatf("timeout: done did not rise in row %0d", r));
            end
            read_ctrl(got, done_pin);
            polls++;
         end
         check_word($sformatf("row %0d done pin after run", r), {31'd0, done_pin}, 32'd1);

         for (int k = 0; k < n + 2; k++) begin
            read_mem(mem_addr(1, k), got);
            if (k < n) begin
               exp = ref_result(rows[r].unit, rows[r].fn, op_a[k], op_b[k]);
            end else begin
               exp = fill_word(r, k);
            end
            check_word($sformatf("row %0d mem1[%0d]", r, k), got, exp);
         end
      end

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
hw/cgra_pkg.sv
hw/cgra_conf_regs.sv
hw/cgra_mem.sv
hw/cgra_alu.sv
hw/cgra_mul.sv
hw/cgra_data_eng.sv
hw/cgra_top.sv
dv/tb_cgra_top.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_cgra_top
LINT_TOP := cgra_top
FILELIST := list.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build lint clean

all: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
